/* source/mips_alu_pkg.sv */
`default_nettype none

package mips_alu_pkg;

	typedef logic [31:0] data_t;
	typedef logic [4:0]  func_t;
	typedef logic [4:0]  shamt_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// function codes.
	// ~~~~~~~~~~~~~~~~~~~~
	localparam func_t FUNC_ADD  = 5'd0;
	localparam func_t FUNC_SUB  = 5'd1;
	localparam func_t FUNC_SLL  = 5'd2;
	localparam func_t FUNC_SRL  = 5'd3;
	localparam func_t FUNC_SRA  = 5'd4;
	localparam func_t FUNC_AND  = 5'd5;
	localparam func_t FUNC_OR   = 5'd6;
	localparam func_t FUNC_NOR  = 5'd7;
	localparam func_t FUNC_XOR  = 5'd8;
	localparam func_t FUNC_SLTS = 5'd9;
	localparam func_t FUNC_SLTU = 5'd10;
	localparam func_t FUNC_MULS = 5'd11;
	localparam func_t FUNC_MULU = 5'd12;
	localparam func_t FUNC_DIVS = 5'd13;
	localparam func_t FUNC_DIVU = 5'd14;
	localparam func_t FUNC_MTLO = 5'd15;
	localparam func_t FUNC_MTHI = 5'd16;
	localparam func_t FUNC_MFLO = 5'd17;
	localparam func_t FUNC_MFHI = 5'd18;

	typedef enum logic [1:0] {
		CLASS_LOGIC,
		CLASS_MULDIV,
		CLASS_MOVE
	} op_class_t;

	// unknown codes fall to the logic unit, which passes data1 through.
	function automatic op_class_t func_class(input func_t f);
		case (f)
			FUNC_MULS, FUNC_MULU, FUNC_DIVS, FUNC_DIVU: return CLASS_MULDIV;
			FUNC_MTLO, FUNC_MTHI, FUNC_MFLO, FUNC_MFHI: return CLASS_MOVE;
			default:                                    return CLASS_LOGIC;
		endcase
	endfunction

endpackage

`default_nettype wire

/* source/alu_logic.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_logic (
	input  logic                clk,
	input  logic                rst,
	input  logic                op_valid,
	input  mips_alu_pkg::func_t func,
	input  mips_alu_pkg::data_t data1,
	input  mips_alu_pkg::data_t data2,
	input  logic                lg_ready,
	output logic                lg_op_ready,
	output logic                lg_valid,
	output mips_alu_pkg::data_t lg_data
);

	import mips_alu_pkg::*;

	shamt_t shamt;
	data_t  result;
	logic   is_logic;
	logic   lg_fire;

	assign shamt    = data2[4:0];
	assign is_logic = (func_class(func) == CLASS_LOGIC);

	// take a new op when the register is empty or drains this cycle.
	assign lg_op_ready = is_logic && (!lg_valid || lg_ready);
	assign lg_fire     = op_valid && lg_op_ready;

	// ~~~~~~~~~~~~~~~~~~~~
	// result mux.
	// ~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (func)
			FUNC_ADD:  result = data1 + data2;
			FUNC_SUB:  result = data1 - data2;
			FUNC_SLL:  result = data1 << shamt;
			FUNC_SRL:  result = data1 >> shamt;
			FUNC_SRA:  result = data_t'($signed(data1) >>> shamt);
			FUNC_AND:  result = data1 & data2;
			FUNC_OR:   result = data1 | data2;
			FUNC_NOR:  result = ~(data1 | data2);
			FUNC_XOR:  result = data1 ^ data2;
			FUNC_SLTS: result = data_t'($signed(data1) < $signed(data2));
			FUNC_SLTU: result = data_t'(data1 < data2);
			default:   result = data1;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// output register.
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			lg_valid <= 1'b0;
		end else if (lg_fire) begin
			lg_valid <= 1'b1;
		end else if (lg_ready) begin
			lg_valid <= 1'b0;
		end
	end

	// payload only moves on a new op.
	always_ff @(posedge clk) begin
		if (lg_fire) begin
			lg_data <= result;
		end
	end

endmodule

`default_nettype wire

/* source/alu_muldiv.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_muldiv #(
	parameter int MUL_LATENCY = 3
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                op_valid,
	input  mips_alu_pkg::func_t func,
	input  mips_alu_pkg::data_t data1,
	input  mips_alu_pkg::data_t data2,
	output logic                md_op_ready,
	output logic                md_busy,
	output logic                md_wr,
	output mips_alu_pkg::data_t md_lo,
	output mips_alu_pkg::data_t md_hi
);

	import mips_alu_pkg::*;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_t;

	logic               is_mul;
	logic               is_div;
	logic               mul_fire;
	logic               div_fire;
	logic signed [63:0] prod_s;
	logic        [63:0] prod_u;
	logic        [63:0] prod;

	logic [MUL_LATENCY-1:0] mul_v;
	data_t                  mul_lo [MUL_LATENCY];
	data_t                  mul_hi [MUL_LATENCY];

	div_state_t  div_state;
	logic [4:0]  div_cnt;
	data_t       div_q;
	data_t       div_r;
	data_t       div_d;
	data_t       div_num;
	logic        div_neg_q;
	logic        div_neg_r;
	logic        div_zero;
	logic [32:0] rem_shift;
	logic        q_bit;
	data_t       div_lo;
	data_t       div_hi;
	logic        pipe_empty;
	logic        div_idle;

	assign is_mul     = (func == FUNC_MULS) || (func == FUNC_MULU);
	assign is_div     = (func == FUNC_DIVS) || (func == FUNC_DIVU);
	assign pipe_empty = ~|mul_v;
	assign div_idle   = (div_state == DIV_IDLE);

	// multiplies wait for the divider, divides wait for both.
	assign md_op_ready = (is_mul && div_idle) || (is_div && div_idle && pipe_empty);
	assign mul_fire    = op_valid && md_op_ready && is_mul;
	assign div_fire    = op_valid && md_op_ready && is_div;
	assign md_busy     = !pipe_empty || !div_idle;

	// ~~~~~~~~~~~~~~~~~~~~
	// multiplier.
	// ~~~~~~~~~~~~~~~~~~~~
	assign prod_s = $signed(data1) * $signed(data2);
	assign prod_u = data1 * data2;
	assign prod   = (func == FUNC_MULS) ? prod_s : prod_u;

	always_ff @(posedge clk) begin
		if (rst) begin
			mul_v <= '0;
		end else begin
			mul_v[0] <= mul_fire;
			for (int i = 1; i < MUL_LATENCY; i++) begin
				mul_v[i] <= mul_v[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		mul_lo[0] <= prod[31:0];
		mul_hi[0] <= prod[63:32];
		for (int i = 1; i < MUL_LATENCY; i++) begin
			mul_lo[i] <= mul_lo[i-1];
			mul_hi[i] <= mul_hi[i-1];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// restoring divider.
	// ~~~~~~~~~~~~~~~~~~~~
	assign rem_shift = {div_r, div_q[31]};
	assign q_bit     = (rem_shift >= {1'b0, div_d});

	always_ff @(posedge clk) begin
		if (rst) begin
			div_state <= DIV_IDLE;
			div_cnt   <= '0;
		end else begin
			case (div_state)
				DIV_IDLE: if (div_fire) begin
					div_state <= DIV_RUN;
					div_cnt   <= '0;
				end
				DIV_RUN: begin
					div_cnt <= div_cnt + 5'd1;
					if (div_cnt == 5'd31) begin
						div_state <= DIV_DONE;
					end
				end
				default: div_state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (div_fire) begin
			// magnitudes in, signs kept for the end.
			div_neg_q <= (func == FUNC_DIVS) && (data1[31] ^ data2[31]);
			div_neg_r <= (func == FUNC_DIVS) && data1[31];
			div_q     <= ((func == FUNC_DIVS) && data1[31]) ? -data1 : data1;
			div_d     <= ((func == FUNC_DIVS) && data2[31]) ? -data2 : data2;
			div_r     <= '0;
			div_zero  <= (data2 == '0);
			div_num   <= data1;
		end else if (div_state == DIV_RUN) begin
			div_r <= q_bit ? data_t'(rem_shift - {1'b0, div_d}) : rem_shift[31:0];
			div_q <= {div_q[30:0], q_bit};
		end
	end

	// zero divisor gives all ones and the dividend back.
	assign div_lo = div_zero ? '1 : (div_neg_q ? -div_q : div_q);
	assign div_hi = div_zero ? div_num : (div_neg_r ? -div_r : div_r);

	assign md_wr = mul_v[MUL_LATENCY-1] || (div_state == DIV_DONE);
	assign md_lo = mul_v[MUL_LATENCY-1] ? mul_lo[MUL_LATENCY-1] : div_lo;
	assign md_hi = mul_v[MUL_LATENCY-1] ? mul_hi[MUL_LATENCY-1] : div_hi;

endmodule

`default_nettype wire

/* source/alu_hilo.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_hilo (
	input  logic                clk,
	input  logic                rst,
	input  logic                op_valid,
	input  mips_alu_pkg::func_t func,
	input  mips_alu_pkg::data_t data1,
	input  logic                lg_valid,
	input  mips_alu_pkg::data_t lg_data,
	input  logic                md_busy,
	input  logic                md_wr,
	input  mips_alu_pkg::data_t md_lo,
	input  mips_alu_pkg::data_t md_hi,
	input  logic                res_ready,
	output logic                mv_op_ready,
	output logic                lg_ready,
	output logic                res_valid,
	output mips_alu_pkg::data_t res_data
);

	import mips_alu_pkg::*;

	data_t reg_lo;
	data_t reg_hi;
	logic  out_free;
	logic  mv_fire;
	logic  mv_read;
	logic  lg_fire;

	assign out_free = !res_valid || res_ready;
	assign lg_ready = out_free;
	assign lg_fire  = lg_valid && lg_ready;

	// moves wait behind muldiv traffic and any pending logic result.
	assign mv_op_ready = (func_class(func) == CLASS_MOVE) && !md_busy && !lg_valid && out_free;
	assign mv_fire     = op_valid && mv_op_ready;
	assign mv_read     = (func == FUNC_MFLO) || (func == FUNC_MFHI);

	// ~~~~~~~~~~~~~~~~~~~~
	// hi and lo.
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			reg_lo <= '0;
			reg_hi <= '0;
		end else if (md_wr) begin
			reg_lo <= md_lo;
			reg_hi <= md_hi;
		end else if (mv_fire && (func == FUNC_MTLO)) begin
			reg_lo <= data1;
		end else if (mv_fire && (func == FUNC_MTHI)) begin
			reg_hi <= data1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// result register.
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else if (lg_fire || (mv_fire && mv_read)) begin
			res_valid <= 1'b1;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (lg_fire) begin
			res_data <= lg_data;
		end else if (mv_fire && mv_read) begin
			res_data <= (func == FUNC_MFHI) ? reg_hi : reg_lo;
		end
	end

endmodule

`default_nettype wire

/* source/alu_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_execute #(
	parameter int MUL_LATENCY = 3
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                op_valid,
	input  mips_alu_pkg::func_t func,
	input  mips_alu_pkg::data_t data1,
	input  mips_alu_pkg::data_t data2,
	input  logic                res_ready,
	output logic                op_ready,
	output logic                res_valid,
	output mips_alu_pkg::data_t res_data
);

	logic                lg_op_ready;
	logic                md_op_ready;
	logic                mv_op_ready;
	logic                lg_valid;
	logic                lg_ready;
	mips_alu_pkg::data_t lg_data;
	logic                md_busy;
	logic                md_wr;
	mips_alu_pkg::data_t md_lo;
	mips_alu_pkg::data_t md_hi;

	// each unit only claims its own class.
	assign op_ready = lg_op_ready || md_op_ready || mv_op_ready;

	alu_logic u_logic (
		.clk         (clk),
		.rst         (rst),
		.op_valid    (op_valid),
		.func        (func),
		.data1       (data1),
		.data2       (data2),
		.lg_ready    (lg_ready),
		.lg_op_ready (lg_op_ready),
		.lg_valid    (lg_valid),
		.lg_data     (lg_data)
	);

	alu_muldiv #(
		.MUL_LATENCY (MUL_LATENCY)
	) u_muldiv (
		.clk         (clk),
		.rst         (rst),
		.op_valid    (op_valid),
		.func        (func),
		.data1       (data1),
		.data2       (data2),
		.md_op_ready (md_op_ready),
		.md_busy     (md_busy),
		.md_wr       (md_wr),
		.md_lo       (md_lo),
		.md_hi       (md_hi)
	);

	alu_hilo u_hilo (
		.clk         (clk),
		.rst         (rst),
		.op_valid    (op_valid),
		.func        (func),
		.data1       (data1),
		.lg_valid    (lg_valid),
		.lg_data     (lg_data),
		.md_busy     (md_busy),
		.md_wr       (md_wr),
		.md_lo       (md_lo),
		.md_hi       (md_hi),
		.res_ready   (res_ready),
		.mv_op_ready (mv_op_ready),
		.lg_ready    (lg_ready),
		.res_valid   (res_valid),
		.res_data    (res_data)
	);

endmodule

`default_nettype wire

/* dv/alu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_tb;

	import mips_alu_pkg::*;

	localparam int          MUL_LATENCY = 3;
	localparam int          OP_LIMIT    = 200;
	localparam int          DRAIN_LIMIT = 2000;
	localparam logic [31:0] SEED        = 32'h9963_a014;

	logic  clk;
	logic  rst;
	logic  op_valid;
	func_t func;
	data_t data1;
	data_t data2;
	logic  res_ready;
	logic  op_ready;
	logic  res_valid;
	data_t res_data;

	data_t       expected_q [$];
	data_t       model_hi;
	data_t       model_lo;
	data_t       exp_word;
	string       test_name;
	logic        stall_on;
	logic [31:0] stim_state;
	logic [31:0] stall_state;

	data_t mul_a [6] = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff,
		32'h0000_0000, 32'hffff_ffff, 32'h7fff_ffff};
	data_t mul_b [6] = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000,
		32'hdead_beef, 32'h0000_0001, 32'h7fff_ffff};
	data_t div_a [8] = '{32'h0000_0064, 32'hffff_ff9c, 32'h0000_0064, 32'hffff_ff9c,
		32'h8000_0000, 32'h0000_3039, 32'hffff_ffff, 32'hffff_fffb};
	data_t div_b [8] = '{32'h0000_0007, 32'h0000_0007, 32'hffff_fff9, 32'hffff_fff9,
		32'hffff_ffff, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000};

	alu_execute #(
		.MUL_LATENCY (MUL_LATENCY)
	) dut0 (
		.clk       (clk),
		.rst       (rst),
		.op_valid  (op_valid),
		.func      (func),
		.data1     (data1),
		.data2     (data2),
		.res_ready (res_ready),
		.op_ready  (op_ready),
		.res_valid (res_valid),
		.res_data  (res_data)
	);

	always #10 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~
	// random source.
	// ~~~~~~~~~~~~~~~~~~~~
	// taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic data_t take_bits(inout logic [31:0] state, input int n);
		data_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_step(state);
			v = {v[30:0], state[0]};
		end
		return v;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// reference model.
	// ~~~~~~~~~~~~~~~~~~~~
	function automatic logic produces_result(input func_t f);
		case (f)
			FUNC_MULS, FUNC_MULU, FUNC_DIVS, FUNC_DIVU, FUNC_MTLO, FUNC_MTHI: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	function automatic data_t model_op(input func_t f, input data_t a, input data_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [63:0] sp;
		logic        [63:0] up;
		shamt_t             s;
		data_t              r;
		s  = b[4:0];
		r  = a;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		case (f)
			FUNC_ADD: r = a + b;
			FUNC_SUB: r = a - b;
			FUNC_SLL: r = a << s;
			FUNC_SRL: r = a >> s;
			FUNC_SRA: begin
				r = a >> s;
				if (a[31]) r = r | ~(32'hffff_ffff >> s);
			end
			FUNC_AND: r = a & b;
			FUNC_OR:  r = a | b;
			FUNC_NOR: r = ~(a | b);
			FUNC_XOR: r = a ^ b;
			// differing signs decide on their own.
			FUNC_SLTS: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
			FUNC_SLTU: r = {31'd0, a < b};
			FUNC_MULS: begin
				sp       = sa * sb;
				model_lo = sp[31:0];
				model_hi = sp[63:32];
			end
			FUNC_MULU: begin
				up       = {32'd0, a} * {32'd0, b};
				model_lo = up[31:0];
				model_hi = up[63:32];
			end
			FUNC_DIVS, FUNC_DIVU: begin
				if (b == '0) begin
					model_lo = '1;
					model_hi = a;
				end else if (f == FUNC_DIVS) begin
					sp       = sa / sb;
					model_lo = sp[31:0];
					sp       = sa % sb;
					model_hi = sp[31:0];
				end else begin
					model_lo = a / b;
					model_hi = a % b;
				end
			end
			FUNC_MTLO: model_lo = a;
			FUNC_MTHI: model_hi = a;
			FUNC_MFLO: r = model_lo;
			FUNC_MFHI: r = model_hi;
			default:   r = a;
		endcase
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// checks and helpers.
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s: expected %08h, actual %08h",
				name, expected, actual));
		end
	endtask

	task automatic issue_op(input func_t f, input data_t a, input data_t b);
		int    waited;
		data_t exp;
		@(negedge clk);
		op_valid = 1'b1;
		func     = f;
		data1    = a;
		data2    = b;
		waited   = 0;
		@(posedge clk);
		while (!op_ready) begin
			waited++;
			if (waited > OP_LIMIT) begin
				abort_run($sformatf("op_ready stayed low for %0d cycles on function code %0d",
					OP_LIMIT, f));
			end
			@(posedge clk);
		end
		exp = model_op(f, a, b);
		if (produces_result(f)) expected_q.push_back(exp);
	endtask

	task automatic run_and_read_hilo(input func_t f, input data_t a, input data_t b);
		issue_op(f, a, b);
		issue_op(FUNC_MFLO, '0, '0);
		issue_op(FUNC_MFHI, '0, '0);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		@(negedge clk);
		op_valid = 1'b0;
		while (expected_q.size() != 0) begin
			waited++;
			if (waited > DRAIN_LIMIT) begin
				abort_run($sformatf("%0d results still missing after %0d cycles in %s",
					expected_q.size(), DRAIN_LIMIT, test_name));
			end
			@(negedge clk);
		end
	endtask

	// output side stalls only when asked to.
	always @(negedge clk) begin
		if (stall_on) begin
			res_ready = take_bits(stall_state, 1) != '0;
		end else begin
			res_ready = 1'b1;
		end
	end

	// compare each output transfer against the queue.
	always @(posedge clk) begin
		if (!rst && res_valid && res_ready) begin
			if (expected_q.size() == 0) begin
				abort_run($sformatf("result %08h arrived with nothing expected in %s",
					res_data, test_name));
			end else begin
				exp_word = expected_q.pop_front();
				check_data(test_name, exp_word, res_data);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// stimulus.
	// ~~~~~~~~~~~~~~~~~~~~
	initial begin
		func_t f;
		data_t a;
		data_t b;
		data_t sel;
		clk         = 1'b0;
		rst         = 1'b1;
		op_valid    = 1'b0;
		func        = '0;
		data1       = '0;
		data2       = '0;
		res_ready   = 1'b1;
		stall_on    = 1'b0;
		model_hi    = '0;
		model_lo    = '0;
		stim_state  = SEED;
		stall_state = SEED;
		test_name   = "reset";
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_name = "logic_random";
		for (int i = 0; i < 200; i++) begin
			f = func_t'(take_bits(stim_state, 4) % 11);
			a = take_bits(stim_state, 32);
			b = take_bits(stim_state, 32);
			issue_op(f, a, b);
		end
		// unknown codes pass operand one.
		issue_op(5'd25, 32'h1234_5678, 32'hffff_0000);
		issue_op(5'd31, 32'hcafe_f00d, 32'h0000_0001);
		wait_drain();

		test_name = "multiply";
		for (int i = 0; i < 14; i++) begin
			if (i < 6) begin
				a = mul_a[i];
				b = mul_b[i];
			end else begin
				a = take_bits(stim_state, 32);
				b = take_bits(stim_state, 32);
			end
			run_and_read_hilo(FUNC_MULS, a, b);
			run_and_read_hilo(FUNC_MULU, a, b);
		end
		wait_drain();

		test_name = "divide";
		for (int i = 0; i < 14; i++) begin
			if (i < 8) begin
				a = div_a[i];
				b = div_b[i];
			end else begin
				a = take_bits(stim_state, 32);
				b = take_bits(stim_state, 12);
			end
			run_and_read_hilo(FUNC_DIVS, a, b);
			run_and_read_hilo(FUNC_DIVU, a, b);
		end
		wait_drain();

		test_name = "move_mix";
		for (int i = 0; i < 60; i++) begin
			sel = take_bits(stim_state, 3);
			a   = take_bits(stim_state, 32);
			b   = take_bits(stim_state, 32);
			case (sel)
				0:       f = FUNC_MTLO;
				1:       f = FUNC_MTHI;
				2:       f = FUNC_MFLO;
				3:       f = FUNC_MFHI;
				default: f = func_t'(take_bits(stim_state, 4) % 11);
			endcase
			issue_op(f, a, b);
		end
		wait_drain();

		test_name = "stall_mix";
		stall_on  = 1'b1;
		for (int i = 0; i < 150; i++) begin
			f = func_t'(take_bits(stim_state, 5) % 19);
			a = take_bits(stim_state, 32);
			b = take_bits(stim_state, 32);
			issue_op(f, a, b);
		end
		wait_drain();
		stall_on = 1'b0;

		test_name = "mul_back_to_back";
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				f = take_bits(stim_state, 1) != '0 ? FUNC_MULS : FUNC_MULU;
				a = take_bits(stim_state, 32);
				b = take_bits(stim_state, 32);
				issue_op(f, a, b);
			end
			issue_op(FUNC_MFLO, '0, '0);
			issue_op(FUNC_MFHI, '0, '0);
		end
		wait_drain();

		// a short quiet spell catches repeated results.
		test_name = "final_idle";
		repeat (10) @(posedge clk);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* mips_alu.f */
source/mips_alu_pkg.sv
source/alu_logic.sv
source/alu_muldiv.sv
source/alu_hilo.sv
source/alu_execute.sv
dv/alu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= alu_tb
LINT_TOP  ?= alu_execute
FILELIST  ?= mips_alu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
SIMFLAGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS)

clean:
	rm -rf $(OBJ_DIR)
